// ==== src/boot_pkg.sv ====
package boot_pkg;

  // Serial frame in 8N1 format
  localparam int clks_per_bit = 434;
  localparam int baud_cnt_w   = $clog2(clks_per_bit);
  localparam int frame_bits   = 10;                    // Start, eight data, stop
  localparam int frame_idx_w  = $clog2(frame_bits);

  // Data words
  localparam int word_w         = 32;
  localparam int byte_w         = 8;
  localparam int bit_idx_w      = $clog2(byte_w);
  localparam int bytes_per_word = 4;
  localparam int byte_cnt_w     = $clog2(bytes_per_word);

  // Memory write address
  localparam int addr_w = 32;                          // Counts words rather than bytes

  // Debug return queue
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = 3;

  // One write toward memory with we high for a single cycle
  typedef struct packed {
    logic              we;
    logic [addr_w-1:0] addr;
    logic [word_w-1:0] data;
  } mem_wr_t;

endpackage

// ==== src/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  output logic [boot_pkg::byte_w-1:0] rx_byte,
  output logic                        rx_valid
);
  import boot_pkg::*;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic [baud_cnt_w-1:0] baud_cnt;
  logic [bit_idx_w-1:0]  bit_idx;
  logic                  half_bit;
  logic                  full_bit;

  assign half_bit = (baud_cnt == baud_cnt_w'(clks_per_bit / 2 - 1));
  assign full_bit = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;                                 // Idle line is high
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        rx_idle: begin
          baud_cnt <= '0;
          if (rx_prev && !rx_sync) state <= rx_start;  // Falling edge
        end
        rx_start: begin
          if (half_bit) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            state    <= rx_sync ? rx_idle : rx_data;   // Glitch if high again
          end
        end
        rx_data: begin
          if (full_bit) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == bit_idx_w'(byte_w - 1)) state <= rx_stop;
          end
        end
        default: begin
          if (full_bit) begin
            rx_valid <= rx_sync;                       // Low stop bit drops the frame
            state    <= rx_idle;
          end
        end
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state == rx_data && full_bit) rx_byte <= {rx_sync, rx_byte[byte_w-1:1]};
  end

endmodule

// ==== src/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        tx_start,
  input  logic [boot_pkg::byte_w-1:0] tx_byte,
  output logic                        tx,
  output logic                        tx_busy,
  output logic                        tx_done
);
  import boot_pkg::*;

  logic [frame_bits-1:0]  frame;
  logic [baud_cnt_w-1:0]  baud_cnt;
  logic [frame_idx_w-1:0] bit_idx;
  logic                   bit_end;

  assign bit_end = (baud_cnt == baud_cnt_w'(clks_per_bit - 1));
  assign tx      = frame[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame    <= '1;                                  // Line idles high
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx_busy  <= 1'b0;
      tx_done  <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (!tx_busy) begin
        if (tx_start) begin
          frame    <= {1'b1, tx_byte, 1'b0};           // Stop, data, start
          baud_cnt <= '0;
          bit_idx  <= '0;
          tx_busy  <= 1'b1;
        end
      end else if (bit_end) begin
        baud_cnt <= '0;
        frame    <= {1'b1, frame[frame_bits-1:1]};
        if (bit_idx == frame_idx_w'(frame_bits - 1)) begin
          tx_busy <= 1'b0;                             // Stop bit has ended
          tx_done <= 1'b1;
        end else begin
          bit_idx <= bit_idx + 1'b1;
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== src/word_assembler.sv ====
`timescale 1ns/100ps

module word_assembler (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [boot_pkg::byte_w-1:0] rx_byte,
  input  logic                        rx_valid,
  output boot_pkg::mem_wr_t           mem_wr
);
  import boot_pkg::*;

  logic [byte_cnt_w-1:0] byte_cnt;
  logic [word_w-1:0]     word_q;
  logic [addr_w-1:0]     addr_q;
  logic                  we_q;
  logic                  last_byte;

  assign last_byte = (byte_cnt == byte_cnt_w'(bytes_per_word - 1));

  // First byte ends up in the top lane after four shifts
  always_ff @(posedge clk) begin
    if (rx_valid) word_q <= {word_q[word_w-byte_w-1:0], rx_byte};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_cnt <= '0;
      we_q     <= 1'b0;
    end else begin
      we_q <= rx_valid && last_byte;
      if (rx_valid) begin
        if (last_byte) byte_cnt <= '0;
        else byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

  // Advance after the write cycle so the strobe carries the old address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (we_q) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  always_comb begin
    mem_wr.we   = we_q;
    mem_wr.addr = addr_q;
    mem_wr.data = word_q;
  end

endmodule

// ==== src/debug_fifo.sv ====
`timescale 1ns/100ps

module debug_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [boot_pkg::word_w-1:0] wr_data,
  input  logic                        wr_en,
  input  logic                        rd_en,
  output logic [boot_pkg::word_w-1:0] rd_data,
  output logic                        full,
  output logic                        empty
);
  import boot_pkg::*;

  logic [word_w-1:0]     mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  push;
  logic                  pop;

  assign full  = (count == (fifo_ptr_w + 1)'(fifo_depth));
  assign empty = (count == '0);
  assign push  = wr_en && !full;                       // Writes while full are lost
  assign pop   = rd_en && !empty;

  assign rd_data = mem[rd_ptr];                        // Head shows without a read

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        if (wr_ptr == fifo_ptr_w'(fifo_depth - 1)) wr_ptr <= '0;
        else wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        if (rd_ptr == fifo_ptr_w'(fifo_depth - 1)) rd_ptr <= '0;
        else rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== src/word_serializer.sv ====
`timescale 1ns/100ps

module word_serializer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [boot_pkg::word_w-1:0] fifo_data,
  input  logic                        fifo_empty,
  output logic                        fifo_pop,
  input  logic                        tx_done,
  output logic                        tx_start,
  output logic [boot_pkg::byte_w-1:0] tx_byte
);
  import boot_pkg::*;

  typedef enum logic [1:0] {
    ser_idle,
    ser_start,
    ser_wait
  } ser_state_t;

  ser_state_t            state;
  logic [word_w-1:0]     shift_q;
  logic [byte_cnt_w-1:0] byte_cnt;

  assign fifo_pop = (state == ser_idle) && !fifo_empty;
  assign tx_start = (state == ser_start);
  assign tx_byte  = shift_q[byte_w-1:0];               // LSB lane goes out first

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      shift_q <= fifo_data;
    end else if (state == ser_wait && tx_done) begin
      shift_q <= {{byte_w{1'b0}}, shift_q[word_w-1:byte_w]};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ser_idle;
      byte_cnt <= '0;
    end else begin
      case (state)
        ser_idle: begin
          byte_cnt <= '0;
          if (!fifo_empty) state <= ser_start;
        end
        ser_start: begin
          state <= ser_wait;                           // Transmitter takes the byte now
        end
        ser_wait: begin
          if (tx_done) begin
            if (byte_cnt == byte_cnt_w'(bytes_per_word - 1)) begin
              state <= ser_idle;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
              state    <= ser_start;
            end
          end
        end
        default: state <= ser_idle;
      endcase
    end
  end

endmodule

// ==== src/bootloader.sv ====
`timescale 1ns/100ps

module bootloader (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        rx,
  output logic                        tx,
  output boot_pkg::mem_wr_t           mem_wr,
  input  logic [boot_pkg::word_w-1:0] dbg_data,
  input  logic                        dbg_write
);
  import boot_pkg::*;

  logic [byte_w-1:0] rx_byte;
  logic              rx_valid;
  logic [word_w-1:0] fifo_data;
  logic              fifo_empty;
  logic              fifo_pop;
  logic              tx_start;
  logic [byte_w-1:0] tx_byte;
  logic              tx_done;

  // Serial in to memory writes
  uart_rx u_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  word_assembler u_word_assembler (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .mem_wr   (mem_wr)
  );

  // Debug words back out on the serial line
  debug_fifo u_debug_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_data (dbg_data),
    .wr_en   (dbg_write),
    .rd_en   (fifo_pop),
    .rd_data (fifo_data),
    .full    (),
    .empty   (fifo_empty)
  );

  word_serializer u_word_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .tx_done    (tx_done),
    .tx_start   (tx_start),
    .tx_byte    (tx_byte)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (),
    .tx_done  (tx_done)
  );

endmodule

// ==== bench/bootloader_tb.sv ====
`timescale 1ns/100ps

module bootloader_tb;
  import boot_pkg::*;

  typedef logic [word_w-1:0] word_list_t[$];

  localparam int     frame_cycles = frame_bits * clks_per_bit;
  localparam int     burst_len    = 12;
  localparam int     accepted_len = fifo_depth + 1; // Queue plus the word held by the serializer
  // Serial frames over all tests with idle checks counted as whole frames
  localparam int     total_frames = 1 + 8 + 5 + 16 + 39 + 16;
  localparam longint watchdog_ns  = longint'(total_frames) * 10 * clks_per_bit * 10 * 2;

  logic              clk;
  logic              rst_n;
  logic              rx;
  logic              tx;
  mem_wr_t           mem_wr;
  logic [word_w-1:0] dbg_data;
  logic              dbg_write;

  integer            seed;
  mem_wr_t           write_q[$];
  logic [addr_w-1:0] next_addr;

  bootloader uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .tx        (tx),
    .mem_wr    (mem_wr),
    .dbg_data  (dbg_data),
    .dbg_write (dbg_write)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (mem_wr.we) write_q.push_back(mem_wr);
  end

  initial begin
    #(watchdog_ns);
    fail_run("Watchdog expired before all tests finished");
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  function automatic logic [word_w-1:0] random_word();
    return $random(seed);
  endfunction

  task automatic send_byte(input logic [byte_w-1:0] data);
    logic [frame_bits-1:0] frame;
    frame = {1'b1, data, 1'b0};                            // Stop, data, start
    @(posedge clk);
    #1;
    for (int i = 0; i < frame_bits; i++) begin
      rx = frame[i];
      repeat (clks_per_bit) @(posedge clk);
      #1;
    end
  endtask

  // High byte goes first so the assembled word equals w
  task automatic send_word(input logic [word_w-1:0] w);
    for (int i = bytes_per_word - 1; i >= 0; i--) send_byte(w[i*byte_w +: byte_w]);
  endtask

  task automatic recv_byte(output logic [byte_w-1:0] data);
    @(negedge tx);
    repeat (clks_per_bit / 2) @(negedge clk);             // Middle of the start bit
    check_value("tx start bit", 32'(tx), 32'h0);
    for (int i = 0; i < byte_w; i++) begin
      repeat (clks_per_bit) @(negedge clk);
      data[i] = tx;
    end
    repeat (clks_per_bit) @(negedge clk);
    check_value("tx stop bit", 32'(tx), 32'h1);
  endtask

  task automatic recv_word(output logic [word_w-1:0] w);
    logic [byte_w-1:0] b;
    for (int i = 0; i < bytes_per_word; i++) begin
      recv_byte(b);
      w[i*byte_w +: byte_w] = b;                           // LSB first on the line
    end
  endtask

  task automatic wait_writes(input int count);
    int waited;
    waited = 0;
    while (write_q.size() < count && waited < 2 * frame_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (write_q.size() < count) fail_run("Expected memory write did not arrive in time");
  endtask

  task automatic expect_write(input logic [word_w-1:0] w);
    mem_wr_t wr;
    wait_writes(1);
    wr = write_q.pop_front();
    check_value("mem_wr.addr", wr.addr, next_addr);
    check_value("mem_wr.data", wr.data, w);
    next_addr = next_addr + 1'b1;
  endtask

  task automatic expect_tx_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("tx idle", 32'(tx), 32'h1);
    end
  endtask

  // One dbg_write per cycle without gaps
  task automatic push_burst(input word_list_t words);
    @(posedge clk);
    #1;
    foreach (words[i]) begin
      dbg_data  = words[i];
      dbg_write = 1'b1;
      @(posedge clk);
      #1;
    end
    dbg_write = 1'b0;
  endtask

  task automatic expect_echo(input word_list_t words);
    logic [word_w-1:0] got;
    foreach (words[i]) begin
      recv_word(got);
      check_value($sformatf("tx word %0d", i), got, words[i]);
    end
  endtask

  task automatic test_reset();
    check_value("tx", 32'(tx), 32'h1);
    check_value("mem_wr.we", 32'(mem_wr.we), 32'h0);
    expect_tx_idle(frame_cycles);
    check_value("write count", 32'(write_q.size()), 32'h0);
  endtask

  task automatic test_word_assembly();
    logic [word_w-1:0] w;
    w = random_word();
    send_word(w);
    expect_write(w);                                       // Lands at address 0
    w = random_word();
    send_word(w);
    expect_write(w);
  endtask

  task automatic test_partial_word();
    logic [word_w-1:0] w;
    w = random_word();
    for (int i = bytes_per_word - 1; i > 0; i--) send_byte(w[i*byte_w +: byte_w]);
    repeat (frame_cycles) @(negedge clk);
    check_value("write count", 32'(write_q.size()), 32'h0);
    send_byte(w[byte_w-1:0]);
    expect_write(w);
  endtask

  task automatic test_debug_echo();
    word_list_t words;
    words = {random_word()};
    push_burst(words);
    expect_echo(words);
    words = {random_word(), random_word(), random_word()};
    push_burst(words);
    expect_echo(words);
  endtask

  task automatic test_overflow();
    word_list_t words;
    word_list_t expected;
    for (int i = 0; i < burst_len; i++) words.push_back(random_word());
    for (int i = 0; i < accepted_len; i++) expected.push_back(words[i]);
    expect_tx_idle(clks_per_bit);                          // Last stop bit ends and the serializer idles
    fork
      push_burst(words);
      expect_echo(expected);                               // First frame starts during the burst
    join
    expect_tx_idle(2 * frame_cycles);                      // Dropped words never show up
  endtask

  task automatic test_full_duplex();
    word_list_t echo_words;
    logic [word_w-1:0] w0;
    logic [word_w-1:0] w1;
    echo_words = {random_word(), random_word()};
    w0 = random_word();
    w1 = random_word();
    fork
      begin
        send_word(w0);
        expect_write(w0);
        send_word(w1);
        expect_write(w1);
      end
      begin
        push_burst(echo_words);
        expect_echo(echo_words);
      end
    join
  endtask

  initial begin
    seed      = 32'h0b6ce782;
    next_addr = '0;
    rst_n     = 1'b0;
    rx        = 1'b1;
    dbg_data  = '0;
    dbg_write = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    test_reset();
    test_word_assembly();
    test_partial_word();
    test_debug_echo();
    test_overflow();
    test_full_duplex();

    if (write_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      fail_run("Memory writes appeared that no test expected");
    end
  end

endmodule

// ==== files.f ====
src/boot_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/word_assembler.sv
src/debug_fifo.sv
src/word_serializer.sv
src/bootloader.sv
bench/bootloader_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bootloader testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module bootloader_tb -o bootloader_sim

./obj_dir/bootloader_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
